// File: src/rv_pkg.sv
`default_nettype none

package rv_pkg;

  localparam int xlen = 32;
  localparam logic [xlen-1:0] reset_pc = 32'h8000_0000;

  // major opcodes, inst[6:0]
  localparam logic [6:0] opc_op_imm = 7'b001_0011;
  localparam logic [6:0] opc_lui    = 7'b011_0111;
  localparam logic [6:0] opc_auipc  = 7'b001_0111;
  localparam logic [6:0] opc_jal    = 7'b110_1111;
  localparam logic [6:0] opc_jalr   = 7'b110_0111;
  localparam logic [6:0] opc_load   = 7'b000_0011;
  localparam logic [6:0] opc_store  = 7'b010_0011;
  localparam logic [6:0] opc_system = 7'b111_0011;

  // access size and signedness for loads and stores
  localparam logic [2:0] f3_b  = 3'b000;
  localparam logic [2:0] f3_h  = 3'b001;
  localparam logic [2:0] f3_w  = 3'b010;
  localparam logic [2:0] f3_bu = 3'b100;
  localparam logic [2:0] f3_hu = 3'b101;

  // one instruction word, four views of the same 32 bits
  typedef union packed {
    struct packed {
      logic [11:0] imm12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i_fmt;
    struct packed {
      logic [6:0]  imm_hi;
      logic [4:0]  rs2;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  imm_lo;
      logic [6:0]  opcode;
    } s_fmt;
    struct packed {
      logic [19:0] imm20;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u_fmt;
    struct packed {
      logic        imm20;     // sign bit
      logic [9:0]  imm10_1;
      logic        imm11;
      logic [7:0]  imm19_12;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } j_fmt;
  } instr_t;

endpackage

`default_nettype wire

// File: src/decode_if.sv
`timescale 1ns/1ps
`default_nettype none

interface decode_if;
  import rv_pkg::*;

  logic [4:0]      rs1;
  logic [4:0]      rs2;
  logic [4:0]      rd;
  logic [2:0]      funct3;
  logic [xlen-1:0] imm;
  logic            op_a_pc;  // adder takes pc instead of rs1
  logic            reg_wen;
  logic            link;     // write back pc+4
  logic            jump;     // next pc from the adder
  logic            load;
  logic            store;

  modport dec (
    output rs1, rs2, rd, funct3, imm, op_a_pc, reg_wen, link, jump, load, store
  );

  modport exe (input imm, op_a_pc, reg_wen, link, jump, load);

  modport lsu (input funct3, load, store);

endinterface

`default_nettype wire

// File: src/rv_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decoder (
  input  logic           rst_n,
  input  rv_pkg::instr_t inst,
  decode_if.dec          dec,
  output logic           halt
);
  import rv_pkg::*;

  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_s;
  logic [xlen-1:0] imm_u;
  logic [xlen-1:0] imm_j;

  assign imm_i = {{20{inst.i_fmt.imm12[11]}}, inst.i_fmt.imm12};
  assign imm_s = {{20{inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi, inst.s_fmt.imm_lo};
  assign imm_u = {inst.u_fmt.imm20, 12'h000};
  assign imm_j = {{11{inst.j_fmt.imm20}}, inst.j_fmt.imm20, inst.j_fmt.imm19_12,
                  inst.j_fmt.imm11, inst.j_fmt.imm10_1, 1'b0};

  always_comb begin
    dec.rs1     = inst.i_fmt.rs1;
    dec.rs2     = inst.s_fmt.rs2;
    dec.rd      = inst.i_fmt.rd;
    dec.funct3  = inst.i_fmt.funct3;
    dec.imm     = '0;
    dec.op_a_pc = 1'b0;
    dec.reg_wen = 1'b0;
    dec.link    = 1'b0;
    dec.jump    = 1'b0;
    dec.load    = 1'b0;
    dec.store   = 1'b0;
    halt        = 1'b0;

    // anything not listed falls through as a plain pc+4 step
    if (rst_n) begin
      case (inst.i_fmt.opcode)
        opc_op_imm: begin
          if (inst.i_fmt.funct3 == 3'b000) begin // addi only
            dec.imm     = imm_i;
            dec.reg_wen = 1'b1;
          end
        end
        opc_lui: begin
          dec.rs1     = 5'd0; // x0 + imm
          dec.imm     = imm_u;
          dec.reg_wen = 1'b1;
        end
        opc_auipc: begin
          dec.imm     = imm_u;
          dec.op_a_pc = 1'b1;
          dec.reg_wen = 1'b1;
        end
        opc_jal: begin
          dec.imm     = imm_j;
          dec.op_a_pc = 1'b1;
          dec.reg_wen = 1'b1;
          dec.link    = 1'b1;
          dec.jump    = 1'b1;
        end
        opc_jalr: begin
          dec.imm     = imm_i;
          dec.reg_wen = 1'b1;
          dec.link    = 1'b1;
          dec.jump    = 1'b1;
        end
        opc_load: begin
          dec.imm     = imm_i;
          dec.reg_wen = 1'b1;
          dec.load    = 1'b1;
        end
        opc_store: begin
          dec.imm   = imm_s;
          dec.store = 1'b1;
        end
        opc_system: begin
          // ebreak is imm12 = 1 with every other field zero
          halt = (inst.i_fmt.imm12 == 12'h001) && (inst.i_fmt.rs1 == 5'd0) &&
                 (inst.i_fmt.funct3 == 3'b000) && (inst.i_fmt.rd == 5'd0);
        end
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: src/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  logic                    clk,
  input  logic                    wen,
  input  logic [4:0]              waddr,
  input  logic [rv_pkg::xlen-1:0] wdata,
  input  logic [4:0]              rs1addr,
  input  logic [4:0]              rs2addr,
  output logic [rv_pkg::xlen-1:0] rs1data,
  output logic [rv_pkg::xlen-1:0] rs2data
);
  import rv_pkg::*;

  logic [xlen-1:0] regs [32];

  always_ff @(posedge clk) begin
    if (wen && (waddr != 5'd0)) begin // x0 never written
      regs[waddr] <= wdata;
    end
  end

  // reads see the old value until the edge
  assign rs1data = (rs1addr == 5'd0) ? '0 : regs[rs1addr];
  assign rs2data = (rs2addr == 5'd0) ? '0 : regs[rs2addr];

endmodule

`default_nettype wire

// File: src/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
  input  logic                    clk,
  input  logic                    rst_n,
  decode_if.exe                   exe,
  input  logic [rv_pkg::xlen-1:0] rs1data,
  input  logic [rv_pkg::xlen-1:0] load_data,
  output logic [rv_pkg::xlen-1:0] pc,
  output logic [rv_pkg::xlen-1:0] addr,
  output logic                    reg_wen,
  output logic [rv_pkg::xlen-1:0] reg_wdata
);
  import rv_pkg::*;

  logic [xlen-1:0] op_a;
  logic [xlen-1:0] sum;
  logic [xlen-1:0] pc_plus4;
  logic [xlen-1:0] next_pc;

  assign op_a     = exe.op_a_pc ? pc : rs1data;
  assign sum      = op_a + exe.imm; // also the load/store address
  assign pc_plus4 = pc + 32'd4;
  assign addr     = sum;

  // bit 0 cleared for jalr, jal targets are even already
  assign next_pc = exe.jump ? {sum[xlen-1:1], 1'b0} : pc_plus4;

  assign reg_wen = exe.reg_wen;

  always_comb begin
    if (exe.link) begin
      reg_wdata = pc_plus4;
    end else if (exe.load) begin
      reg_wdata = load_data;
    end else begin
      reg_wdata = sum;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= reset_pc;
    end else begin
      pc <= next_pc;
    end
  end

endmodule

`default_nettype wire

// File: src/load_store_unit.sv
`timescale 1ns/1ps
`default_nettype none

module load_store_unit (
  decode_if.lsu                   lsu,
  input  logic [rv_pkg::xlen-1:0] addr,
  input  logic [rv_pkg::xlen-1:0] rs2data,
  input  logic [rv_pkg::xlen-1:0] mem_rdata,
  output logic [rv_pkg::xlen-1:0] mem_addr,
  output logic [rv_pkg::xlen-1:0] mem_wdata,
  output logic [3:0]              mem_wmask,
  output logic                    mem_ren,
  output logic                    mem_wen,
  output logic [rv_pkg::xlen-1:0] load_data
);
  import rv_pkg::*;

  logic [1:0]      ofs;
  logic [3:0]      byte_mask;
  logic            store_ok;
  logic [xlen-1:0] lane_word;

  assign ofs = addr[1:0];

  // zero mask on a misaligned access
  always_comb begin
    case (lsu.funct3)
      f3_b, f3_bu: byte_mask = 4'b0001 << ofs;
      f3_h, f3_hu: byte_mask = ofs[0] ? 4'b0000 : (4'b0011 << ofs);
      f3_w:        byte_mask = (ofs == 2'b00) ? 4'b1111 : 4'b0000;
      default:     byte_mask = 4'b0000;
    endcase
  end

  assign store_ok = lsu.store && !lsu.funct3[2] && (byte_mask != 4'b0000); // sb/sh/sw

  assign mem_addr  = {addr[xlen-1:2], 2'b00};
  assign mem_wdata = rs2data << {ofs, 3'b000}; // into its byte lane
  assign mem_wmask = store_ok ? byte_mask : 4'b0000;
  assign mem_wen   = store_ok;
  assign mem_ren   = lsu.load && (byte_mask != 4'b0000);

  // addressed lane moved down to bit 0
  assign lane_word = mem_rdata >> {ofs, 3'b000};

  always_comb begin
    load_data = '0;
    if (byte_mask != 4'b0000) begin
      case (lsu.funct3)
        f3_b:    load_data = {{24{lane_word[7]}}, lane_word[7:0]};
        f3_bu:   load_data = {24'h00_0000, lane_word[7:0]};
        f3_h:    load_data = {{16{lane_word[15]}}, lane_word[15:0]};
        f3_hu:   load_data = {16'h0000, lane_word[15:0]};
        f3_w:    load_data = lane_word;
        default: load_data = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: src/rv_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_top (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [31:0]             inst,
  output logic [rv_pkg::xlen-1:0] pc,
  output logic [rv_pkg::xlen-1:0] mem_addr,
  output logic [rv_pkg::xlen-1:0] mem_wdata,
  output logic [3:0]              mem_wmask,
  output logic                    mem_ren,
  output logic                    mem_wen,
  input  logic [rv_pkg::xlen-1:0] mem_rdata,
  output logic                    halt
);
  import rv_pkg::*;

  logic [xlen-1:0] rs1data;
  logic [xlen-1:0] rs2data;
  logic [xlen-1:0] addr;       // adder output
  logic            reg_wen;
  logic [xlen-1:0] reg_wdata;
  logic [xlen-1:0] load_data;

  decode_if dec_bus ();

  rv_decoder i_decoder (
    .rst_n (rst_n),
    .inst  (instr_t'(inst)),
    .dec   (dec_bus.dec),
    .halt  (halt)
  );

  reg_file i_reg_file (
    .clk     (clk),
    .wen     (reg_wen),
    .waddr   (dec_bus.rd),
    .wdata   (reg_wdata),
    .rs1addr (dec_bus.rs1),
    .rs2addr (dec_bus.rs2),
    .rs1data (rs1data),
    .rs2data (rs2data)
  );

  execute_stage i_execute (
    .clk       (clk),
    .rst_n     (rst_n),
    .exe       (dec_bus.exe),
    .rs1data   (rs1data),
    .load_data (load_data),
    .pc        (pc),
    .addr      (addr),
    .reg_wen   (reg_wen),
    .reg_wdata (reg_wdata)
  );

  load_store_unit i_lsu (
    .lsu       (dec_bus.lsu),
    .addr      (addr),
    .rs2data   (rs2data),
    .mem_rdata (mem_rdata),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wmask (mem_wmask),
    .mem_ren   (mem_ren),
    .mem_wen   (mem_wen),
    .load_data (load_data)
  );

endmodule

`default_nettype wire

// File: bench/tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

function automatic logic [31:0] enc_i(logic [6:0] opc, logic [4:0] rd, logic [2:0] f3,
                                      logic [4:0] rs1, logic [11:0] imm);
  rv_pkg::instr_t w;
  w.i_fmt = '{imm, rs1, f3, rd, opc};
  return w;
endfunction

function automatic logic [31:0] enc_s(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                      logic [11:0] imm);
  rv_pkg::instr_t w;
  w.s_fmt = '{imm[11:5], rs2, rs1, f3, imm[4:0], rv_pkg::opc_store};
  return w;
endfunction

function automatic logic [31:0] enc_u(logic [6:0] opc, logic [4:0] rd, logic [19:0] imm);
  rv_pkg::instr_t w;
  w.u_fmt = '{imm, rd, opc};
  return w;
endfunction

function automatic logic [31:0] enc_j(logic [4:0] rd, logic [20:0] ofs);
  rv_pkg::instr_t w;
  w.j_fmt = '{ofs[20], ofs[10:1], ofs[11], ofs[19:12], rd, rv_pkg::opc_jal};
  return w;
endfunction

function automatic logic [31:0] sext12(logic [11:0] v);
  return {{20{v[11]}}, v};
endfunction

// byte enables spread to bit lanes
function automatic logic [31:0] lanes(logic [3:0] m);
  logic [31:0] r;
  for (int k = 0; k < 4; k++) begin
    r[8*k +: 8] = {8{m[k]}};
  end
  return r;
endfunction

task automatic add_row(logic [31:0] w, logic st, logic [31:0] a, logic [31:0] d,
                       logic [3:0] m, logic h, logic [31:0] npc);
  row_inst[num_rows] = w;
  row_pc[num_rows]   = cur_pc;
  row_st[num_rows]   = st;
  row_addr[num_rows] = a;
  row_data[num_rows] = d;
  row_mask[num_rows] = m;
  row_halt[num_rows] = h;
  row_ld[num_rows]   = 1'b0;
  num_rows++;
  cur_pc = npc;
endtask

task automatic set_reg(logic [4:0] rd, logic [31:0] v);
  if (rd != 5'd0) begin
    xr[rd] = v; // x0 stays zero
  end
endtask

task automatic i_row(logic [31:0] w, logic [4:0] rd, logic [31:0] v);
  set_reg(rd, v);
  add_row(w, 1'b0, 32'd0, 32'd0, 4'd0, 1'b0, cur_pc + 32'd4);
endtask

// store from x0-based address, expected lanes from the access size
task automatic st_row(logic [2:0] f3, logic [4:0] rs2, logic [11:0] off);
  logic [31:0] a;
  logic [3:0]  m;
  logic [31:0] d;
  int          n;
  int          o;
  a = sext12(off);
  case (f3)
    rv_pkg::f3_b: n = 1;
    rv_pkg::f3_h: n = 2;
    default:      n = 4;
  endcase
  o = int'(a[1:0]);
  m = 4'd0;
  d = 32'd0;
  if (o % n == 0) begin // naturally aligned only
    for (int k = 0; k < n; k++) begin
      m[o + k] = 1'b1;
      d[8*(o + k) +: 8] = xr[rs2][8*k +: 8];
    end
  end
  add_row(enc_s(f3, 5'd0, rs2, off), m != 4'd0, {a[31:2], 2'b00}, d, m, 1'b0,
          cur_pc + 32'd4);
endtask

task automatic ld_row(logic [2:0] f3, logic [4:0] rd, logic [11:0] off);
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] v;
  logic        al;
  a = sext12(off);
  b = init_words[a[5:2]] >> (8 * a[1:0]);
  case (f3)
    rv_pkg::f3_b:  v = {{24{b[7]}}, b[7:0]};
    rv_pkg::f3_bu: v = {24'd0, b[7:0]};
    rv_pkg::f3_h:  v = {{16{b[15]}}, b[15:0]};
    rv_pkg::f3_hu: v = {16'd0, b[15:0]};
    default:       v = b;
  endcase
  case (f3)
    rv_pkg::f3_h, rv_pkg::f3_hu: al = !a[0];
    rv_pkg::f3_w:                al = (a[1:0] == 2'b00);
    default:                     al = 1'b1;
  endcase
  if (!al) begin
    v = 32'd0; // misaligned reads back zero
  end
  i_row(enc_i(rv_pkg::opc_load, rd, f3, 5'd0, off), rd, v);
  row_ld[num_rows - 1] = al;
  st_row(rv_pkg::f3_w, rd, 12'd0);
endtask

task automatic build_program();
  logic [31:0] t;
  cur_pc = rv_pkg::reset_pc;
  num_rows = 0;
  for (int r = 0; r < 32; r++) begin
    xr[r] = 32'd0;
  end
  i_row(enc_i(rv_pkg::opc_op_imm, 5'd1, 3'd0, 5'd0, 12'h123), 5'd1, sext12(12'h123));
  st_row(rv_pkg::f3_w, 5'd1, 12'd0);
  i_row(enc_i(rv_pkg::opc_op_imm, 5'd2, 3'd0, 5'd0, 12'hffb), 5'd2, sext12(12'hffb));
  st_row(rv_pkg::f3_w, 5'd2, 12'd4);
  i_row(enc_u(rv_pkg::opc_lui, 5'd3, 20'habcde), 5'd3, {20'habcde, 12'h000});
  st_row(rv_pkg::f3_w, 5'd3, 12'd8);
  i_row(enc_u(rv_pkg::opc_auipc, 5'd4, 20'h12345), 5'd4, cur_pc + {20'h12345, 12'h000});
  st_row(rv_pkg::f3_w, 5'd4, 12'd12);
  t = cur_pc + 32'd12; // jal forward
  set_reg(5'd5, cur_pc + 32'd4);
  add_row(enc_j(5'd5, 21'd12), 1'b0, 32'd0, 32'd0, 4'd0, 1'b0, t);
  st_row(rv_pkg::f3_w, 5'd5, 12'd16);
  t = (xr[4] + 32'd5) & ~32'd1; // odd target, bit 0 dropped
  set_reg(5'd6, cur_pc + 32'd4);
  add_row(enc_i(rv_pkg::opc_jalr, 5'd6, 3'd0, 5'd4, 12'd5), 1'b0, 32'd0, 32'd0, 4'd0,
          1'b0, t);
  st_row(rv_pkg::f3_w, 5'd6, 12'd20);
  t = cur_pc - 32'd8; // backward jal, link into x0
  add_row(enc_j(5'd0, 21'h1ffff8), 1'b0, 32'd0, 32'd0, 4'd0, 1'b0, t);
  st_row(rv_pkg::f3_w, 5'd0, 12'd24);
  i_row(enc_i(rv_pkg::opc_op_imm, 5'd0, 3'd0, 5'd0, 12'h007), 5'd0, 32'd7);
  st_row(rv_pkg::f3_w, 5'd0, 12'd24);
  i_row(enc_u(rv_pkg::opc_lui, 5'd7, 20'h89abc), 5'd7, {20'h89abc, 12'h000});
  i_row(enc_i(rv_pkg::opc_op_imm, 5'd7, 3'd0, 5'd7, 12'h5ef), 5'd7, xr[7] + 32'h5ef);
  for (int k = 0; k < 4; k++) begin
    st_row(rv_pkg::f3_b, 5'd7, 12'(28 + k));
  end
  st_row(rv_pkg::f3_h, 5'd7, 12'd28);
  st_row(rv_pkg::f3_h, 5'd7, 12'd30);
  st_row(rv_pkg::f3_w, 5'd7, 12'd28);
  st_row(rv_pkg::f3_h, 5'd7, 12'd29); // misaligned
  st_row(rv_pkg::f3_w, 5'd7, 12'd30); // misaligned
  ld_row(rv_pkg::f3_b, 5'd8, 12'd33);
  ld_row(rv_pkg::f3_bu, 5'd9, 12'd35);
  ld_row(rv_pkg::f3_h, 5'd10, 12'd38);
  ld_row(rv_pkg::f3_hu, 5'd11, 12'd42);
  ld_row(rv_pkg::f3_w, 5'd12, 12'd44);
  add_row(32'h0010_0073, 1'b0, 32'd0, 32'd0, 4'd0, 1'b1, cur_pc + 32'd4); // ebreak
  add_row(32'h0020_81b3, 1'b0, 32'd0, 32'd0, 4'd0, 1'b0, cur_pc + 32'd4); // add, unsupported
  st_row(rv_pkg::f3_w, 5'd3, 12'd8); // x3 untouched by the add
endtask

`endif

// File: bench/rv_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;
  import rv_pkg::*;

  localparam int max_rows = 64;

  logic        clk;
  logic        rst_n;
  logic [31:0] inst;
  logic [31:0] pc;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic [3:0]  mem_wmask;
  logic        mem_ren;
  logic        mem_wen;
  logic [31:0] mem_rdata;
  logic        halt;

  logic [31:0] mem [16];
  logic [31:0] init_words [16]; // random preload

  logic [31:0] row_inst [max_rows];
  logic [31:0] row_pc [max_rows];
  logic        row_st [max_rows];
  logic [31:0] row_addr [max_rows];
  logic [31:0] row_data [max_rows];
  logic [3:0]  row_mask [max_rows];
  logic        row_halt [max_rows];
  logic        row_ld [max_rows];   // expected mem_ren
  int          num_rows;
  logic [31:0] cur_pc;
  logic [31:0] xr [32];   // expected register contents
  logic        build_done = 1'b0;

  `include "tb_program.svh"

  rv_core_top i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .inst      (inst),
    .pc        (pc),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wmask (mem_wmask),
    .mem_ren   (mem_ren),
    .mem_wen   (mem_wen),
    .mem_rdata (mem_rdata),
    .halt      (halt)
  );

  always #50 clk = ~clk;

  assign mem_rdata = mem[mem_addr[5:2]];

  always @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 16; i++) begin
        mem[i] <= init_words[i];
      end
    end else if (mem_wen) begin
      for (int k = 0; k < 4; k++) begin
        if (mem_wmask[k]) begin
          mem[mem_addr[5:2]][8*k +: 8] <= mem_wdata[8*k +: 8];
        end
      end
    end
  end

  task automatic check_val(string name, logic [31:0] exp_v, logic [31:0] act);
    assert (act === exp_v) else begin
      $display("mismatch at %0t: %s expected %h got %h", $time, name, exp_v, act);
      $display("TESTBENCH FAILED");
      $fatal(1, "stopped at first error");
    end
  endtask

  initial begin
    clk   = 1'b0;
    rst_n = 1'b0;
    inst  = 32'h0000_0013; // nop
    void'($urandom(32'hd975c7c4));
    for (int i = 0; i < 16; i++) begin
      init_words[i] = $urandom;
    end
    build_program();
    build_done = 1'b1;

    // a store, then an ebreak, both held off by reset
    @(posedge clk);
    inst <= enc_s(f3_w, 5'd0, 5'd0, 12'd0);
    @(negedge clk);
    check_val("mem_wen", 32'd0, 32'(mem_wen));
    @(posedge clk);
    inst <= 32'h0010_0073;
    @(negedge clk);
    check_val("halt", 32'd0, 32'(halt));

    for (int i = 0; i < num_rows; i++) begin
      @(posedge clk);
      rst_n <= 1'b1;
      inst  <= row_inst[i];
      @(negedge clk);
      check_val("pc", row_pc[i], pc);
      check_val("halt", 32'(row_halt[i]), 32'(halt));
      check_val("mem_wen", 32'(row_st[i]), 32'(mem_wen));
      check_val("mem_ren", 32'(row_ld[i]), 32'(mem_ren));
      if (row_st[i]) begin
        check_val("mem_addr", row_addr[i], mem_addr);
        check_val("mem_wmask", 32'(row_mask[i]), 32'(mem_wmask));
        check_val("mem_wdata", row_data[i], mem_wdata & lanes(mem_wmask));
      end
    end

    $display("TESTBENCH PASSED");
    $finish;
  end

  initial begin
    wait (build_done);
    #((num_rows + 10) * 100);
    $display("watchdog timeout, the table did not finish in time");
    $display("TESTBENCH FAILED");
    $fatal(1, "timeout");
  end

endmodule

`default_nettype wire

// File: rv_core_top.f
+incdir+bench
src/rv_pkg.sv
src/decode_if.sv
src/rv_decoder.sv
src/reg_file.sv
src/execute_stage.sv
src/load_store_unit.sv
src/rv_core_top.sv
bench/rv_core_tb.sv

// File: Makefile
SRCS := $(wildcard src/*.sv) bench/rv_core_tb.sv bench/tb_program.svh

all: run

obj_dir/Vrv_core_tb: rv_core_top.f $(SRCS)
	verilator --binary --timing --top-module rv_core_tb -f rv_core_top.f -o Vrv_core_tb

run: obj_dir/Vrv_core_tb
	obj_dir/Vrv_core_tb > sim.log 2>&1; cat sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
